// ==== Bender.yml ====
package:
  name: uart_wb

sources:
  - include_dirs:
      - .
    files:
      - uart_pkg.sv
      - uart_baud_gen.sv
      - uart_tx.sv
      - uart_rx.sv
      - uart_wb_regs.sv
      - uart_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - uart_asserts.sv
      - uart_tb.sv

// ==== uart_asserts.sv ====
`timescale 1ns/1ps

module uart_asserts (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic tx_busy,
    input logic tx_load
);

    int fail_count = 0; // Assertion failures seen so far

    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack stayed high for two consecutive clocks");
        end

    // Ack must answer a request sampled on the previous edge
    ack_after_req: assert property (@(posedge clk) disable iff (rst)
                                    wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            fail_count++;
            $error("wb_ack without a preceding cyc and stb cycle");
        end

    load_when_idle: assert property (@(posedge clk) disable iff (rst) tx_load |-> !tx_busy)
        else begin
            fail_count++;
            $error("tx_load pulsed while the transmitter was busy");
        end

endmodule

bind uart_wb_regs uart_asserts u_asserts (
    .clk     (clk),
    .rst     (rst),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .tx_busy (tx_busy),
    .tx_load (tx_load)
);

// ==== uart_baud_gen.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_baud_gen (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CNT_W = $clog2(`UART_BAUD_DIV + 1);

    logic [CNT_W-1:0] cnt; // Clocks left in the current tick period

    // Down counter, tick is registered so it is a clean one-clock pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= CNT_W'(`UART_BAUD_DIV);
            tick <= 1'b0;
        end else if (cnt == CNT_W'(1)) begin
            cnt  <= CNT_W'(`UART_BAUD_DIV); // Reload on wrap
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// ==== uart_macros.svh ====
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Baud generator and bit timing
`define UART_BAUD_DIV      4   // Clocks per oversampling tick
`define UART_OVERSAMPLE    16  // Ticks per serial bit

// Width of one serial data word
`define UART_DATA_W        8

// Bit positions in the STATUS register
`define UART_ST_TX_BUSY    0   // Transmitter shifting a frame
`define UART_ST_RX_VALID   1   // Receive holding register full
`define UART_ST_FRAME_ERR  2   // Stop bit seen low
`define UART_ST_PARITY_ERR 3   // Parity bit mismatch
`define UART_ST_OVERRUN    4   // Byte lost, holding register was full

`endif

// ==== uart_pkg.sv ====
package uart_pkg;

    // Transmitter FSM states
    typedef enum logic [2:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_parity,
        tx_stop
    } tx_state_t;

    // Receiver FSM states
    typedef enum logic [2:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_parity,
        rx_stop
    } rx_state_t;

    // Wishbone register map
    typedef enum logic [1:0] {
        addr_data   = 2'd0,
        addr_status = 2'd1,
        addr_ctrl   = 2'd2
    } reg_addr_t;

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_rx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tick,
    input  logic                    rx,
    input  logic                    parity_en,
    input  logic                    parity_odd,
    output logic [`UART_DATA_W-1:0] rx_byte,
    output logic                    rx_done,
    output logic                    frame_err,
    output logic                    parity_err
);

    localparam int TCNT_W = $clog2(`UART_OVERSAMPLE);
    localparam int BCNT_W = $clog2(`UART_DATA_W);

    uart_pkg::rx_state_t     state;
    logic                    rx_meta;  // First synchronizer stage
    logic                    rx_s;     // Synchronized line
    logic [TCNT_W-1:0]       tick_cnt;
    logic [BCNT_W-1:0]       bit_cnt;
    logic [`UART_DATA_W-1:0] shift;
    logic                    par_bad;  // Parity mismatch of the current frame
    logic                    mid_tick;
    logic                    full_tick;
    logic                    sample;

    // Start bit is confirmed half a bit in, later bits one full bit apart
    assign mid_tick  = tick && (tick_cnt == TCNT_W'(`UART_OVERSAMPLE / 2 - 1));
    assign full_tick = tick && (tick_cnt == TCNT_W'(`UART_OVERSAMPLE - 1));
    assign sample    = (state == uart_pkg::rx_start) ? mid_tick : full_tick;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    // Received bits, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == uart_pkg::rx_data && sample) begin
            shift <= {rx_s, shift[`UART_DATA_W-1:1]};
        end
        if (state == uart_pkg::rx_stop && sample) begin
            rx_byte <= shift;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= uart_pkg::rx_idle;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            par_bad    <= 1'b0;
            rx_done    <= 1'b0;
            frame_err  <= 1'b0;
            parity_err <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            if (state == uart_pkg::rx_idle) begin
                tick_cnt <= '0;
            end else if (tick) begin
                tick_cnt <= sample ? '0 : tick_cnt + 1'b1;
            end

            case (state)
                uart_pkg::rx_idle: begin
                    if (tick && !rx_s) begin
                        state <= uart_pkg::rx_start;
                    end
                end
                uart_pkg::rx_start: begin
                    if (sample) begin
                        bit_cnt <= '0;
                        par_bad <= 1'b0;
                        state   <= rx_s ? uart_pkg::rx_idle : uart_pkg::rx_data; // Glitch check
                    end
                end
                uart_pkg::rx_data: begin
                    if (sample) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BCNT_W'(`UART_DATA_W - 1)) begin
                            state <= parity_en ? uart_pkg::rx_parity : uart_pkg::rx_stop;
                        end
                    end
                end
                uart_pkg::rx_parity: begin
                    if (sample) begin
                        par_bad <= rx_s ^ (^shift) ^ parity_odd;
                        state   <= uart_pkg::rx_stop;
                    end
                end
                uart_pkg::rx_stop: begin
                    if (sample) begin
                        rx_done    <= 1'b1; // Middle of the stop bit
                        frame_err  <= !rx_s;
                        parity_err <= par_bad;
                        state      <= uart_pkg::rx_idle;
                    end
                end
                default: state <= uart_pkg::rx_idle;
            endcase
        end
    end

endmodule

// ==== uart_tb.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tb;

    localparam int CLK_PERIOD  = 100; // ns
    localparam int BIT_CLKS    = `UART_BAUD_DIV * `UART_OVERSAMPLE; // Clocks per serial bit
    localparam int ACK_TIMEOUT = 16;
    localparam logic [4:0] ST_BUSY  = 5'(1 << `UART_ST_TX_BUSY);
    localparam logic [4:0] ST_VALID = 5'(1 << `UART_ST_RX_VALID);
    localparam logic [4:0] ST_FERR  = 5'(1 << `UART_ST_FRAME_ERR);
    localparam logic [4:0] ST_PERR  = 5'(1 << `UART_ST_PARITY_ERR);
    localparam logic [4:0] ST_OVR   = 5'(1 << `UART_ST_OVERRUN);

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    uart_pkg::reg_addr_t     wb_adr;
    logic [`UART_DATA_W-1:0] wb_dat_w;
    logic [`UART_DATA_W-1:0] wb_dat_r;
    logic                    wb_ack;
    logic                    rx;
    logic                    tx;

    int     err_count     = 0;
    int     timeout_count = 0;
    integer seed          = 56569;

    uart_top dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .rx       (rx),
        .tx       (tx)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Frame bits in line order: start, data LSB first, optional parity, stop
    function automatic logic [11:0] expected_frame(input logic [7:0] b, input logic pen,
                                                   input logic podd, output int n);
        logic [11:0] f;
        f      = '0;
        f[8:1] = b;
        if (pen) begin
            // Even parity makes the count of ones, parity bit included, even
            f[9]  = podd ? ($countones(b) % 2 == 0) : ($countones(b) % 2 == 1);
            f[10] = 1'b1;
            n     = 11;
        end else begin
            f[9] = 1'b1;
            n    = 10;
        end
        return f;
    endfunction

    task automatic wb_access(input uart_pkg::reg_addr_t adr, input logic we,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        int n;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        n        = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < ACK_TIMEOUT);
        if (!wb_ack) begin
            $display("Timeout at %0t ns: no wb_ack for access to %s", $time, adr.name());
            timeout_count++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input uart_pkg::reg_addr_t adr, input logic [7:0] data);
        logic [7:0] unused;
        wb_access(adr, 1'b1, data, unused);
    endtask

    task automatic wb_read(input uart_pkg::reg_addr_t adr, output logic [7:0] data);
        wb_access(adr, 1'b0, 8'h00, data);
    endtask

    // Serial line model, one bit per BIT_CLKS clocks plus one idle bit
    task automatic send_frame(input logic [7:0] b, input logic pen, input logic podd,
                              input logic bad_parity, input logic bad_stop);
        logic [11:0] bits;
        int          n;
        bits = expected_frame(b, pen, podd, n);
        if (bad_parity) bits[9] = ~bits[9];
        if (bad_stop) bits[n-1] = 1'b0;
        @(negedge clk);
        for (int i = 0; i < n; i++) begin
            rx = bits[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        rx = 1'b1;
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    task automatic capture_frame(input int n, output logic [11:0] bits, output time t_start);
        int t;
        bits    = '0;
        t       = 0;
        t_start = $time;
        while (tx && t < 8 * BIT_CLKS) begin
            @(negedge clk);
            t++;
        end
        if (tx) begin
            $display("Timeout at %0t ns: no start bit seen on tx", $time);
            timeout_count++;
        end else begin
            t_start = $time; // Falling edge of the start bit
            repeat (BIT_CLKS / 2) @(negedge clk); // Middle of the start bit
            for (int i = 0; i < n; i++) begin
                bits[i] = tx;
                if (i < n - 1) repeat (BIT_CLKS) @(negedge clk);
            end
        end
    endtask

    task automatic poll_status(input int bit_pos, input logic level);
        logic [7:0] st;
        int         n;
        n = 0;
        do begin
            wb_read(uart_pkg::addr_status, st);
            n++;
        end while (st[bit_pos] !== level && n < 400);
        if (st[bit_pos] !== level) begin
            $display("Timeout at %0t ns: STATUS bit %0d never became %b", $time, bit_pos, level);
            timeout_count++;
        end
    endtask

    // Frame length in bits, from the start edge to the fall of busy
    task automatic measure_frame_len(input time t_start, output int n_bits);
        time clks;
        poll_status(`UART_ST_TX_BUSY, 1'b0);
        clks   = ($time - t_start) / CLK_PERIOD;
        n_bits = int'((clks + BIT_CLKS / 2) / BIT_CLKS);
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_status(input logic [4:0] got, input logic [4:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s STATUS is %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_frame(input logic [11:0] got, input int got_n,
                               input logic [11:0] exp, input int exp_n);
        if (got !== exp || got_n != exp_n) begin
            $display("Error at %0t ns: tx frame %0d bits %b, expected %0d bits %b",
                     $time, got_n, got, exp_n, exp);
            err_count++;
        end
    endtask

    initial begin
        logic [7:0]  b;
        logic [7:0]  b2;
        logic [7:0]  rd;
        logic [11:0] exp_bits;
        logic [11:0] got_bits;
        int          exp_n;
        int          got_n;
        time         t_start;
        logic        pen;
        logic        podd;
        int          t;

        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = uart_pkg::addr_data;
        wb_dat_w = '0;
        rx       = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        if (tx !== 1'b1) begin
            $display("Error at %0t ns: tx is %b after reset, expected 1", $time, tx);
            err_count++;
        end
        wb_read(uart_pkg::addr_status, rd);
        check_status(rd[4:0], 5'b0, "after reset");

        // Transmit path under no parity, even and odd
        for (int mode = 0; mode < 3; mode++) begin
            pen  = (mode != 0);
            podd = (mode == 2);
            wb_write(uart_pkg::addr_ctrl, {6'b0, podd, pen});
            wb_read(uart_pkg::addr_ctrl, rd);
            check_byte(rd, {6'b0, podd, pen}, "CTRL readback");
            repeat (12) begin
                b        = 8'($random(seed));
                exp_bits = expected_frame(b, pen, podd, exp_n);
                wb_write(uart_pkg::addr_data, b);
                fork
                    capture_frame(exp_n, got_bits, t_start);
                    begin
                        wb_read(uart_pkg::addr_status, rd);
                        check_status(rd[4:0], ST_BUSY, "after DATA write");
                    end
                join
                measure_frame_len(t_start, got_n);
                check_frame(got_bits, got_n, exp_bits, exp_n);
            end

            // Receive path with the same line setting
            repeat (4) begin
                b = 8'($random(seed));
                send_frame(b, pen, podd, 1'b0, 1'b0);
                poll_status(`UART_ST_RX_VALID, 1'b1);
                wb_read(uart_pkg::addr_data, rd);
                check_byte(rd, b, "received DATA");
                wb_read(uart_pkg::addr_status, rd);
                check_status(rd[4:0], 5'b0, "after DATA read");
            end
        end

        // Parity error, then framing error, each with even parity
        wb_write(uart_pkg::addr_ctrl, 8'h01);
        b = 8'($random(seed));
        send_frame(b, 1'b1, 1'b0, 1'b1, 1'b0);
        poll_status(`UART_ST_RX_VALID, 1'b1);
        wb_read(uart_pkg::addr_status, rd);
        check_status(rd[4:0], ST_VALID | ST_PERR, "bad parity");
        wb_read(uart_pkg::addr_data, rd);
        check_byte(rd, b, "DATA with bad parity");
        wb_read(uart_pkg::addr_status, rd);
        check_status(rd[4:0], 5'b0, "parity flag cleared");
        b = 8'($random(seed));
        send_frame(b, 1'b1, 1'b0, 1'b0, 1'b1);
        poll_status(`UART_ST_RX_VALID, 1'b1);
        wb_read(uart_pkg::addr_status, rd);
        check_status(rd[4:0], ST_VALID | ST_FERR, "low stop bit");
        wb_read(uart_pkg::addr_data, rd);
        check_byte(rd, b, "DATA with low stop bit");
        wb_read(uart_pkg::addr_status, rd);
        check_status(rd[4:0], 5'b0, "frame flag cleared");

        // Overrun keeps the first byte
        wb_write(uart_pkg::addr_ctrl, 8'h00);
        b  = 8'($random(seed));
        b2 = 8'($random(seed));
        send_frame(b, 1'b0, 1'b0, 1'b0, 1'b0);
        send_frame(b2, 1'b0, 1'b0, 1'b0, 1'b0);
        poll_status(`UART_ST_RX_VALID, 1'b1);
        wb_read(uart_pkg::addr_status, rd);
        check_status(rd[4:0], ST_VALID | ST_OVR, "overrun");
        wb_read(uart_pkg::addr_data, rd);
        check_byte(rd, b, "DATA after overrun");
        wb_read(uart_pkg::addr_status, rd);
        check_status(rd[4:0], 5'b0, "overrun cleared");

        // Second write lands while busy and must be dropped
        exp_bits = expected_frame(b, 1'b0, 1'b0, exp_n);
        fork
            capture_frame(exp_n, got_bits, t_start);
            begin
                wb_write(uart_pkg::addr_data, b);
                wb_write(uart_pkg::addr_data, b2);
            end
        join
        measure_frame_len(t_start, got_n);
        check_frame(got_bits, got_n, exp_bits, exp_n);
        t = 0;
        while (tx && t < 3 * BIT_CLKS) begin
            @(negedge clk);
            t++;
        end
        if (!tx) begin
            $display("Error at %0t ns: second frame started, busy write was sent", $time);
            err_count++;
        end
        poll_status(`UART_ST_TX_BUSY, 1'b0);

        $display("Checks done: %0d errors, %0d timeouts, %0d assertion failures",
                 err_count, timeout_count, dut.u_regs.u_asserts.fail_count);
        if (err_count == 0 && timeout_count == 0 && dut.u_regs.u_asserts.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== uart_top.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  uart_pkg::reg_addr_t     wb_adr,
    input  logic [`UART_DATA_W-1:0] wb_dat_w,
    output logic [`UART_DATA_W-1:0] wb_dat_r,
    output logic                    wb_ack,
    input  logic                    rx,
    output logic                    tx
);

    logic                    tick;       // Shared 16x oversampling tick
    logic                    tx_load;
    logic [`UART_DATA_W-1:0] tx_byte;
    logic                    tx_busy;
    logic                    parity_en;
    logic                    parity_odd;
    logic [`UART_DATA_W-1:0] rx_byte;
    logic                    rx_done;
    logic                    frame_err;
    logic                    parity_err;

    uart_baud_gen u_baud_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_tx u_tx (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .tx_load    (tx_load),
        .tx_byte    (tx_byte),
        .parity_en  (parity_en),
        .parity_odd (parity_odd),
        .tx         (tx),
        .tx_busy    (tx_busy)
    );

    uart_rx u_rx (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .rx         (rx),
        .parity_en  (parity_en),
        .parity_odd (parity_odd),
        .rx_byte    (rx_byte),
        .rx_done    (rx_done),
        .frame_err  (frame_err),
        .parity_err (parity_err)
    );

    uart_wb_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .tx_busy    (tx_busy),
        .tx_load    (tx_load),
        .tx_byte    (tx_byte),
        .parity_en  (parity_en),
        .parity_odd (parity_odd),
        .rx_byte    (rx_byte),
        .rx_done    (rx_done),
        .frame_err  (frame_err),
        .parity_err (parity_err)
    );

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tick,
    input  logic                    tx_load,
    input  logic [`UART_DATA_W-1:0] tx_byte,
    input  logic                    parity_en,
    input  logic                    parity_odd,
    output logic                    tx,
    output logic                    tx_busy
);

    localparam int TCNT_W = $clog2(`UART_OVERSAMPLE);
    localparam int BCNT_W = $clog2(`UART_DATA_W);

    uart_pkg::tx_state_t     state;
    logic [TCNT_W-1:0]       tick_cnt; // Ticks into the current bit
    logic [BCNT_W-1:0]       bit_cnt;  // Data bit index
    logic [`UART_DATA_W-1:0] shift;
    logic                    par_bit;  // Parity bit for the latched byte
    logic                    par_on;   // Parity setting frozen for this frame
    logic                    bit_end;

    assign bit_end = tick && (tick_cnt == TCNT_W'(`UART_OVERSAMPLE - 1));

    // Frame payload, captured at load and shifted after each data bit
    always_ff @(posedge clk) begin
        if (state == uart_pkg::tx_idle && tx_load) begin
            shift   <= tx_byte;
            par_bit <= ^tx_byte ^ parity_odd;
            par_on  <= parity_en;
        end else if (state == uart_pkg::tx_data && bit_end) begin
            shift <= shift >> 1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= uart_pkg::tx_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1; // Line idles high
            tx_busy  <= 1'b0;
        end else begin
            if (state == uart_pkg::tx_idle) begin
                tick_cnt <= '0;
            end else if (tick) begin
                tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
            end

            case (state)
                uart_pkg::tx_idle: begin
                    if (tx_load) begin
                        tx_busy <= 1'b1;
                    end else if (tx_busy && tick) begin
                        tx    <= 1'b0; // Start bit aligned to a tick
                        state <= uart_pkg::tx_start;
                    end
                end
                uart_pkg::tx_start: begin
                    if (bit_end) begin
                        tx      <= shift[0]; // LSB first
                        bit_cnt <= '0;
                        state   <= uart_pkg::tx_data;
                    end
                end
                uart_pkg::tx_data: begin
                    if (bit_end) begin
                        if (bit_cnt == BCNT_W'(`UART_DATA_W - 1)) begin
                            tx    <= par_on ? par_bit : 1'b1;
                            state <= par_on ? uart_pkg::tx_parity : uart_pkg::tx_stop;
                        end else begin
                            tx      <= shift[1]; // Next bit, shift moves on this edge
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::tx_parity: begin
                    if (bit_end) begin
                        tx    <= 1'b1; // Stop bit
                        state <= uart_pkg::tx_stop;
                    end
                end
                uart_pkg::tx_stop: begin
                    if (bit_end) begin
                        tx_busy <= 1'b0;
                        state   <= uart_pkg::tx_idle;
                    end
                end
                default: state <= uart_pkg::tx_idle;
            endcase
        end
    end

endmodule

// ==== uart_wb_regs.sv ====
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_wb_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  uart_pkg::reg_addr_t     wb_adr,
    input  logic [`UART_DATA_W-1:0] wb_dat_w,
    output logic [`UART_DATA_W-1:0] wb_dat_r,
    output logic                    wb_ack,
    input  logic                    tx_busy,
    output logic                    tx_load,
    output logic [`UART_DATA_W-1:0] tx_byte,
    output logic                    parity_en,
    output logic                    parity_odd,
    input  logic [`UART_DATA_W-1:0] rx_byte,
    input  logic                    rx_done,
    input  logic                    frame_err,
    input  logic                    parity_err
);

    logic                    req;      // New Wishbone request this clock
    logic                    data_wr;
    logic                    data_rd;
    logic                    ctrl_wr;
    logic                    tx_free;
    logic                    rx_valid;
    logic                    overrun;
    logic                    frame_flag;
    logic                    parity_flag;
    logic [`UART_DATA_W-1:0] rx_hold;  // Receive holding register
    logic [`UART_DATA_W-1:0] status;

    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign data_wr = req && wb_we && (wb_adr == uart_pkg::addr_data);
    assign data_rd = req && !wb_we && (wb_adr == uart_pkg::addr_data);
    assign ctrl_wr = req && wb_we && (wb_adr == uart_pkg::addr_ctrl);
    assign tx_free = !tx_busy; // Transmitter can take a new byte

    always_comb begin
        status                      = '0;
        status[`UART_ST_TX_BUSY]    = tx_busy;
        status[`UART_ST_RX_VALID]   = rx_valid;
        status[`UART_ST_FRAME_ERR]  = frame_flag;
        status[`UART_ST_PARITY_ERR] = parity_flag;
        status[`UART_ST_OVERRUN]    = overrun;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack      <= 1'b0;
            tx_load     <= 1'b0;
            parity_en   <= 1'b0;
            parity_odd  <= 1'b0;
            rx_valid    <= 1'b0;
            overrun     <= 1'b0;
            frame_flag  <= 1'b0;
            parity_flag <= 1'b0;
        end else begin
            wb_ack  <= req;                // Single-cycle ack, no wait states
            tx_load <= data_wr && tx_free; // Busy writes are acked and dropped
            if (ctrl_wr) begin
                parity_en  <= wb_dat_w[0];
                parity_odd <= wb_dat_w[1];
            end
            // A byte arriving during the DATA read stays valid
            rx_valid    <= rx_done || (rx_valid && !data_rd);
            overrun     <= (overrun && !data_rd) || (rx_done && rx_valid && !data_rd);
            frame_flag  <= (frame_flag && !data_rd) || (rx_done && frame_err);
            parity_flag <= (parity_flag && !data_rd) || (rx_done && parity_err);
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr && tx_free) begin
            tx_byte <= wb_dat_w;
        end
        if (rx_done && (!rx_valid || data_rd)) begin
            rx_hold <= rx_byte; // Old byte kept on overrun
        end
        if (req && !wb_we) begin
            case (wb_adr)
                uart_pkg::addr_data:   wb_dat_r <= rx_hold;
                uart_pkg::addr_status: wb_dat_r <= status;
                uart_pkg::addr_ctrl:   wb_dat_r <= {{(`UART_DATA_W - 2){1'b0}}, parity_odd, parity_en};
                default:               wb_dat_r <= '0;
            endcase
        end
    end

endmodule

// ==== vlog.f ====
+incdir+.
uart_pkg.sv
uart_baud_gen.sv
uart_tx.sv
uart_rx.sv
uart_wb_regs.sv
uart_top.sv
uart_asserts.sv
uart_tb.sv
